//--- Makefile
VERILATOR ?= verilator
TOP       ?= pdp8_mem_tb
FILELIST  ?= pdp8_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) include/pdp8_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)

check: run
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/pdp8_macros.svh
`ifndef PDP8_MACROS_SVH
`define PDP8_MACROS_SVH

// machine word width
`define WORD_W 12

// 1: 13-bit memory address, only the low field bit is used
// 0: full 15-bit extended address with all three field bits
`define ADDR_W13 0

// RAM words, follows the address width choice
`define MEM_DEPTH (1 << ((`ADDR_W13 != 0) ? 13 : 15))

`endif

//--- pdp8_mem.f
+incdir+include
source/pdp8_pkg.sv
source/mem_bus_if.sv
source/core_ram.sv
source/memory_address.sv
source/major_state_seq.sv
source/pc_ac_unit.sv
source/pdp8_mem_top.sv
tb/tb_clock_gen.sv
tb/pdp8_mem_checker.sv
tb/pdp8_mem_tb.sv

//--- source/core_ram.sv
`timescale 1ns/10ps
`include "pdp8_macros.svh"

module core_ram (
    input logic       clk,
    mem_bus_if.memory mem
);

    localparam int AW = $clog2(`MEM_DEPTH);

    logic [`WORD_W-1:0] words [0:`MEM_DEPTH-1];
    logic [`WORD_W+2:0] ext_addr;
    logic [AW-1:0]      index;

    assign ext_addr = {mem.field, mem.addr};
    assign index    = ext_addr[AW-1:0];  // 13-bit mode keeps only the low field bit

    always_ff @(posedge clk)
    begin
        if (mem.we)
        begin
            words[index] <= mem.wdata;
        end
        mem.rdata <= words[index];  // old word on a write cycle
    end

endmodule

//--- source/major_state_seq.sv
`timescale 1ns/10ps

module major_state_seq (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  logic                   halt_req,
    input  pdp8_pkg::instr_word_t  instruction,
    output pdp8_pkg::major_state_t state,
    output logic                   running
);

    pdp8_pkg::major_state_t next_state;
    logic                   halt_pend;
    logic                   go_halt;
    logic                   is_hlt;
    logic                   mem_ref;
    logic                   needs_exec;

    assign mem_ref    = (instruction.mr.opcode <= pdp8_pkg::JMP);
    assign needs_exec = (instruction.mr.opcode <= pdp8_pkg::JMS);  // and tad isz dca jms
    assign is_hlt     = (instruction.op.opcode == pdp8_pkg::OPR) &&
                        instruction.op.group && instruction.op.hlt;
    assign go_halt    = halt_pend || halt_req;
    assign running    = !(state inside {pdp8_pkg::H0, pdp8_pkg::H1, pdp8_pkg::H2, pdp8_pkg::H3});

    always_comb
    begin
        case (state)
            pdp8_pkg::F3:
                if (mem_ref && instruction.mr.indirect)
                    next_state = pdp8_pkg::D0;
                else if (needs_exec)
                    next_state = pdp8_pkg::E0;
                else if (go_halt || is_hlt)
                    next_state = pdp8_pkg::H0;
                else
                    next_state = pdp8_pkg::F0;
            pdp8_pkg::D3:
                if (needs_exec)
                    next_state = pdp8_pkg::E0;
                else
                    next_state = go_halt ? pdp8_pkg::H0 : pdp8_pkg::F0;
            pdp8_pkg::E3:
                next_state = go_halt ? pdp8_pkg::H0 : pdp8_pkg::F0;
            pdp8_pkg::H3:
                next_state = run ? pdp8_pkg::F0 : pdp8_pkg::H0;
            default:
                next_state = pdp8_pkg::major_state_t'(state + 4'd1);  // next phase
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= pdp8_pkg::H0;
            halt_pend <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if ((state == pdp8_pkg::H3) && run)
                halt_pend <= 1'b0;
            else if (halt_req)
                halt_pend <= 1'b1;  // held until the cycle ends
        end
    end

endmodule

//--- source/mem_bus_if.sv
`timescale 1ns/10ps
`include "pdp8_macros.svh"

interface mem_bus_if;
    logic [`WORD_W-1:0] addr;
    logic [2:0]         field;
    logic [`WORD_W-1:0] wdata;
    logic               we;
    logic [`WORD_W-1:0] rdata;

    modport master (output addr, output field, output wdata, output we, input rdata);
    modport memory (input addr, input field, input wdata, input we, output rdata);
endinterface

//--- source/memory_address.sv
`timescale 1ns/10ps
`include "pdp8_macros.svh"

module memory_address (
    input  logic                  clk,
    input  logic                  reset,
    input  pdp8_pkg::major_state_t state,
    input  logic [`WORD_W-1:0]    pc,
    input  logic [`WORD_W-1:0]    ac,
    input  logic [`WORD_W-1:0]    sr,
    input  logic                  addr_load,
    input  logic                  deposit,
    input  logic                  examine,
    input  logic                  int_in_prog,
    input  logic [2:0]            if_field,
    input  logic [2:0]            df_field,
    output pdp8_pkg::instr_word_t instruction,
    output logic [`WORD_W-1:0]    ma,
    output logic                  isz_skip,
    mem_bus_if.master             mem
);

    logic [`WORD_W-1:0] read_word;
    logic               mem_ref;
    logic               data_ref;
    logic               data_field;
    logic               auto_index;

    assign read_word  = mem.rdata;
    assign mem_ref    = (instruction.mr.opcode != pdp8_pkg::IOT) &&
                        (instruction.mr.opcode != pdp8_pkg::OPR);
    assign data_ref   = (instruction.mr.opcode == pdp8_pkg::AND) ||
                        (instruction.mr.opcode == pdp8_pkg::TAD) ||
                        (instruction.mr.opcode == pdp8_pkg::ISZ) ||
                        (instruction.mr.opcode == pdp8_pkg::DCA);
    assign data_field = data_ref && instruction.mr.indirect;
    assign auto_index = (ma[`WORD_W-1:3] == 9'o001);  // 0010 to 0017

    // address, field and write control
    always_comb
    begin
        mem.addr  = ma;
        mem.field = if_field;
        mem.we    = 1'b0;
        mem.wdata = ac;
        case (state)
            pdp8_pkg::F0, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3:
                mem.addr = pc;
            pdp8_pkg::D1:
            begin
                mem.we    = auto_index;
                mem.wdata = read_word + 1'b1;  // pre-increment pointer
            end
            pdp8_pkg::E0, pdp8_pkg::E2, pdp8_pkg::E3:
                if (data_field)
                begin
                    mem.field = df_field;
                end
            pdp8_pkg::E1:
            begin
                if (data_field)
                begin
                    mem.field = df_field;
                end
                case (instruction.mr.opcode)
                    pdp8_pkg::ISZ:
                    begin
                        mem.we    = 1'b1;
                        mem.wdata = read_word + 1'b1;
                    end
                    pdp8_pkg::JMS:
                    begin
                        mem.we    = 1'b1;
                        mem.wdata = pc;  // return address
                    end
                    pdp8_pkg::DCA:
                    begin
                        mem.we    = 1'b1;
                        mem.wdata = ac;
                    end
                    default: ;
                endcase
            end
            pdp8_pkg::H1:
            begin
                mem.we    = deposit && !addr_load;
                mem.wdata = sr;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ma          <= '0;
            isz_skip    <= 1'b0;
            instruction <= pdp8_pkg::instr_word_t'(12'o7000);
        end
        else
        begin
            case (state)
                pdp8_pkg::F1:
                    instruction <= pdp8_pkg::instr_word_t'(read_word);
                pdp8_pkg::F2:
                    // pc still points at this instruction, so its page is the current page
                    if (mem_ref)
                    begin
                        if (instruction.mr.page)
                        begin
                            ma <= {pc[`WORD_W-1:7], instruction.mr.offset};
                        end
                        else
                        begin
                            ma <= {5'b00000, instruction.mr.offset};
                        end
                    end
                pdp8_pkg::D2:
                    if (auto_index)
                    begin
                        ma <= read_word + 1'b1;  // memory held the old pointer
                    end
                    else
                    begin
                        ma <= read_word;
                    end
                pdp8_pkg::E0:
                    if (int_in_prog)
                    begin
                        instruction <= pdp8_pkg::instr_word_t'(12'o4000);  // jms 0
                        ma          <= '0;
                    end
                pdp8_pkg::E1:
                    if ((instruction.mr.opcode == pdp8_pkg::ISZ) && (read_word == 12'o7777))
                    begin
                        isz_skip <= 1'b1;
                    end
                pdp8_pkg::E3:
                    isz_skip <= 1'b0;
                pdp8_pkg::H1:
                    if (addr_load)
                    begin
                        ma <= sr;
                    end
                pdp8_pkg::H2:
                    if (deposit || examine)
                    begin
                        ma <= ma + 1'b1;
                    end
                default: ;
            endcase
        end
    end

endmodule

//--- source/pc_ac_unit.sv
`timescale 1ns/10ps
`include "pdp8_macros.svh"

module pc_ac_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_pkg::major_state_t state,
    input  pdp8_pkg::instr_word_t  instruction,
    input  logic [`WORD_W-1:0]     ma,
    input  logic [`WORD_W-1:0]     mdout,
    input  logic                   isz_skip,
    input  logic [`WORD_W-1:0]     sr,
    input  logic                   addr_load,
    output logic [`WORD_W-1:0]     pc,
    output logic [`WORD_W-1:0]     ac
);

    logic jmp_op;
    logic cla_op;

    assign jmp_op = (instruction.mr.opcode == pdp8_pkg::JMP);
    assign cla_op = (instruction.op.opcode == pdp8_pkg::OPR) &&
                    !instruction.op.group && instruction.op.cla;  // group 1 cla only

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
            ac <= '0;
        end
        else
        begin
            case (state)
                pdp8_pkg::F2:
                    pc <= pc + 1'b1;
                pdp8_pkg::F3:
                begin
                    if (jmp_op && !instruction.mr.indirect)
                        pc <= ma;
                    if (cla_op)
                        ac <= '0;
                end
                pdp8_pkg::D3:
                    if (jmp_op)
                        pc <= ma;  // ma holds the deferred target
                pdp8_pkg::E2:
                    case (instruction.mr.opcode)
                        pdp8_pkg::AND: ac <= ac & mdout;
                        pdp8_pkg::TAD: ac <= ac + mdout;  // no link
                        pdp8_pkg::DCA: ac <= '0;
                        default: ;
                    endcase
                pdp8_pkg::E3:
                    if (instruction.mr.opcode == pdp8_pkg::JMS)
                        pc <= ma + 1'b1;
                    else if (isz_skip)
                        pc <= pc + 1'b1;
                pdp8_pkg::H1:
                    if (addr_load)
                        pc <= sr;
                default: ;
            endcase
        end
    end

endmodule

//--- source/pdp8_mem_top.sv
`timescale 1ns/10ps
`include "pdp8_macros.svh"

module pdp8_mem_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  logic               halt_req,
    input  logic [`WORD_W-1:0] sr,
    input  logic               addr_load,
    input  logic               deposit,
    input  logic               examine,
    input  logic               int_in_prog,
    input  logic [2:0]         if_field,
    input  logic [2:0]         df_field,
    output logic [`WORD_W-1:0] pc,
    output logic [`WORD_W-1:0] ac,
    output logic [`WORD_W-1:0] ma,
    output logic [`WORD_W-1:0] mdout,
    output logic [3:0]         state,
    output logic               running
);

    pdp8_pkg::major_state_t major_state;
    pdp8_pkg::instr_word_t  instruction;
    logic                   isz_skip;

    mem_bus_if bus ();

    assign state = major_state;
    assign mdout = bus.rdata;

    core_ram u_ram (.clk(clk), .mem(bus.memory));

    memory_address u_ma (
        .clk(clk), .reset(reset), .state(major_state), .pc(pc), .ac(ac), .sr(sr),
        .addr_load(addr_load), .deposit(deposit), .examine(examine),
        .int_in_prog(int_in_prog), .if_field(if_field), .df_field(df_field),
        .instruction(instruction), .ma(ma), .isz_skip(isz_skip), .mem(bus.master)
    );

    major_state_seq u_seq (
        .clk(clk), .reset(reset), .run(run), .halt_req(halt_req),
        .instruction(instruction), .state(major_state), .running(running)
    );

    pc_ac_unit u_pc_ac (
        .clk(clk), .reset(reset), .state(major_state), .instruction(instruction),
        .ma(ma), .mdout(mdout), .isz_skip(isz_skip), .sr(sr), .addr_load(addr_load),
        .pc(pc), .ac(ac)
    );

endmodule

//--- source/pdp8_pkg.sv
package pdp8_pkg;

    // four phases in each of fetch, defer, execute and halt
    typedef enum logic [3:0] {
        F0, F1, F2, F3,
        D0, D1, D2, D3,
        E0, E1, E2, E3,
        H0, H1, H2, H3
    } major_state_t;

    typedef enum logic [2:0] {
        AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
    } opcode_t;

    // memory reference view
    typedef struct packed {
        opcode_t    opcode;
        logic       indirect;
        logic       page;  // 0 page zero, 1 current page
        logic [6:0] offset;
    } mem_ref_t;

    // operate view, group 2 micro-op layout
    typedef struct packed {
        opcode_t    opcode;
        logic       group;
        logic       cla;
        logic [4:0] micro;  // sma sza snl rev osr
        logic       hlt;
        logic       spare;
    } operate_t;

    typedef union packed {
        mem_ref_t mr;
        operate_t op;
    } instr_word_t;

endpackage

//--- tb/pdp8_mem_checker.sv
`timescale 1ns/10ps

module pdp8_mem_checker (
    input logic                   clk,
    input logic                   reset,
    input pdp8_pkg::major_state_t state,
    input logic                   we,
    input logic [2:0]             field,
    input logic [2:0]             if_field,
    input logic [2:0]             df_field,
    input logic                   isz_skip
);

    assert property (@(posedge clk) disable iff (reset)
        we |-> (state inside {pdp8_pkg::D1, pdp8_pkg::E1, pdp8_pkg::H1}))
        else $error("memory write outside D1, E1 or H1");

    // data field only reaches the bus during execute
    assert property (@(posedge clk) disable iff (reset)
        ((field == df_field) && (df_field != if_field)) |->
        (state inside {pdp8_pkg::E0, pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::E3}))
        else $error("data field selected outside execute");

    assert property (@(posedge clk) disable iff (reset)
        $fell(isz_skip) |-> ($past(state) == pdp8_pkg::E3))
        else $error("isz skip dropped outside E3");

    assert property (@(posedge clk) disable iff (reset)
        ((state[3:2] != 2'b11) && (state[1:0] != 2'b11)) |=>
        (state == pdp8_pkg::major_state_t'($past(state) + 4'd1)))
        else $error("phase did not advance by one");

endmodule

bind memory_address pdp8_mem_checker u_checker (
    .clk(clk), .reset(reset), .state(state), .we(mem.we), .field(mem.field),
    .if_field(if_field), .df_field(df_field), .isz_skip(isz_skip)
);

//--- tb/pdp8_mem_tb.sv
`timescale 1ns/10ps
`include "pdp8_macros.svh"

module pdp8_mem_tb;

    localparam int PANEL_OPS   = 180;
    localparam int RUNS        = 7;
    localparam int RUN_CYCLES  = 20 * 12 + 16;  // up to 20 instructions plus start and halt
    localparam int CYCLE_LIMIT = PANEL_OPS * 4 + RUNS * RUN_CYCLES + 300;

    logic               clk;
    logic               reset;
    logic               run;
    logic               halt_req;
    logic [`WORD_W-1:0] sr;
    logic               addr_load;
    logic               deposit;
    logic               examine;
    logic               int_in_prog;
    logic [2:0]         if_field;
    logic [2:0]         df_field;
    logic [`WORD_W-1:0] pc;
    logic [`WORD_W-1:0] ac;
    logic [`WORD_W-1:0] ma;
    logic [`WORD_W-1:0] mdout;
    logic [3:0]         state;
    logic               running;

    logic [11:0] model_mem [0:(1 << 15) - 1];
    logic [11:0] model_ac;
    logic [11:0] model_pc;
    logic [31:0] rand_state;
    int          error_count;
    int          cycles;

    tb_clock_gen #(.PERIOD(4.0)) u_clk (.clk(clk));

    pdp8_mem_top u_dut (
        .clk(clk), .reset(reset), .run(run), .halt_req(halt_req), .sr(sr),
        .addr_load(addr_load), .deposit(deposit), .examine(examine),
        .int_in_prog(int_in_prog), .if_field(if_field), .df_field(df_field),
        .pc(pc), .ac(ac), .ma(ma), .mdout(mdout), .state(state), .running(running)
    );

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [11:0] pick_origin();
        logic [31:0] r;
        r = next_random();
        return 12'o0400 + {r[18:16], 7'b0};  // page aligned, pages 2 to 9
    endfunction

    // reference interpreter over model_mem, stops at hlt
    function automatic void interpret(input logic [11:0] start);
        logic [11:0] instr;
        logic [11:0] here;
        logic [11:0] ea;
        logic [11:0] m;
        logic [2:0]  op;
        logic [14:0] dloc;
        int          steps;
        model_pc = start;
        for (steps = 0; steps < 20; steps++)
        begin
            here     = model_pc;
            instr    = model_mem[{if_field, here}];
            model_pc = here + 12'd1;
            op       = instr[11:9];
            if (op == 3'd7)
            begin
                if (instr[8] && instr[1])
                    return;
                if (!instr[8] && instr[7])
                    model_ac = '0;
            end
            else if (op != 3'd6)
            begin
                ea = instr[7] ? {here[11:7], instr[6:0]} : {5'b0, instr[6:0]};
                if (instr[8])
                begin
                    if (ea[11:3] == 9'o001)
                        model_mem[{if_field, ea}] = model_mem[{if_field, ea}] + 12'd1;
                    ea = model_mem[{if_field, ea}];
                end
                if (op == 3'd5)
                    model_pc = ea;
                else if (int_in_prog)
                begin
                    model_mem[{if_field, 12'o0000}] = model_pc;  // forced jms 0
                    model_pc = 12'o0001;
                end
                else
                begin
                    dloc = {((op != 3'd4) && instr[8]) ? df_field : if_field, ea};
                    m    = model_mem[dloc];
                    case (op)
                        3'd0: model_ac = model_ac & m;
                        3'd1: model_ac = model_ac + m;
                        3'd2:
                        begin
                            model_mem[dloc] = m + 12'd1;
                            if (m == 12'o7777)
                                model_pc = model_pc + 12'd1;
                        end
                        3'd3:
                        begin
                            model_mem[dloc] = model_ac;
                            model_ac = '0;
                        end
                        default:
                        begin
                            model_mem[dloc] = model_pc;
                            model_pc = ea + 12'd1;
                        end
                    endcase
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [11:0] exp, input logic [11:0] got);
        assert (got === exp)
        else
        begin
            $display("ERROR %0s expected %o actual %o", name, exp, got);
            error_count++;
            $display("Something failed");
            $fatal(1, "mismatch in %0s", name);
        end
    endtask

    task automatic wait_for(input pdp8_pkg::major_state_t s);
        while (state != s)
            @(negedge clk);
    endtask

    // one halt cycle with the front-panel strobes held, returns mdout at H3
    task automatic panel(input logic al, input logic dep, input logic ex,
                         input logic [11:0] value, output logic [11:0] seen);
        wait_for(pdp8_pkg::H3);
        sr        = value;
        addr_load = al;
        deposit   = dep;
        examine   = ex;
        @(negedge clk);
        wait_for(pdp8_pkg::H3);
        seen      = mdout;
        addr_load = 1'b0;
        deposit   = 1'b0;
        examine   = 1'b0;
    endtask

    task automatic put(input logic [2:0] field, input logic [11:0] addr, input logic [11:0] word);
        logic [11:0] seen;
        if_field = field;
        panel(1'b1, 1'b0, 1'b0, addr, seen);
        panel(1'b0, 1'b1, 1'b0, word, seen);
        if_field = 3'd0;
        model_mem[{field, addr}] = word;
    endtask

    task automatic check_mem(input string name, input logic [2:0] field, input logic [11:0] addr);
        logic [11:0] seen;
        if_field = field;
        panel(1'b1, 1'b0, 1'b0, addr, seen);
        panel(1'b0, 1'b0, 1'b1, 12'o0000, seen);
        if_field = 3'd0;
        check_value(name, model_mem[{field, addr}], seen);
    endtask

    // comparison of a whole program run against the reference
    task automatic run_and_compare(input string name, input logic [11:0] origin);
        logic [11:0] seen;
        panel(1'b1, 1'b0, 1'b0, origin, seen);
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
        check_value({name, " start state"}, pdp8_pkg::F0, state);
        check_value({name, " running"}, 1'b1, running);
        wait_for(pdp8_pkg::H0);
        check_value({name, " halted"}, 1'b0, running);
        interpret(origin);
        check_value({name, " ac"}, model_ac, ac);
        check_value({name, " pc"}, model_pc, pc);
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the machine never halted", cycles);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        logic [11:0] p;
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] seen;
        logic [11:0] words [0:5];
        logic [31:0] r;
        reset       = 1'b1;
        run         = 1'b0;
        halt_req    = 1'b0;
        sr          = '0;
        addr_load   = 1'b0;
        deposit     = 1'b0;
        examine     = 1'b0;
        int_in_prog = 1'b0;
        if_field    = 3'd0;
        df_field    = 3'd0;
        rand_state  = 32'ha0e0_dc65;
        model_ac    = '0;
        error_count = 0;
        cycles      = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // machine comes out of reset halted with cleared registers
        check_value("reset state", pdp8_pkg::H0, state);
        check_value("reset running", 1'b0, running);
        check_value("reset ma", 12'o0000, ma);
        check_value("reset pc", 12'o0000, pc);
        check_value("reset ac", 12'o0000, ac);

        // deposit a block, then examine it back
        r = next_random();
        a = 12'o7000 + r[7:0];
        panel(1'b1, 1'b0, 1'b0, a, seen);
        for (int i = 0; i < 6; i++)
        begin
            r = next_random();
            words[i] = r[27:16];
            panel(1'b0, 1'b1, 1'b0, words[i], seen);
        end
        panel(1'b1, 1'b0, 1'b0, a, seen);
        for (int i = 0; i < 6; i++)
        begin
            panel(1'b0, 1'b0, 1'b1, 12'o0000, seen);
            check_value("deposit examine", words[i], seen);
        end
        check_value("ma after examine", a + 12'd6, ma);

        // tad, and, dca on page zero and current page
        p = pick_origin();
        r = next_random();
        a = 12'o0040 + r[4:0];
        b = a + 12'o0040;
        put(0, p, 12'o7200);
        put(0, p + 1, 12'o1000 | a);
        put(0, p + 2, 12'o1320);
        put(0, p + 3, 12'o0000 | b);
        put(0, p + 4, 12'o3321);
        put(0, p + 5, 12'o1320);
        put(0, p + 6, 12'o7402);
        r = next_random();
        put(0, a, r[11:0]);
        put(0, b, r[27:16]);
        r = next_random();
        put(0, p + 12'o120, r[11:0]);
        put(0, p + 12'o121, r[27:16]);
        run_and_compare("mem ref", p);
        check_mem("dca store", 0, p + 12'o121);

        // isz on 7777 and on another value
        for (int k = 0; k < 2; k++)
        begin
            p = pick_origin();
            r = next_random();
            put(0, p, 12'o7200);
            put(0, p + 1, 12'o2300);
            put(0, p + 2, 12'o1301);
            put(0, p + 3, 12'o1302);
            put(0, p + 4, 12'o7402);
            put(0, p + 12'o100, (k == 0) ? 12'o7777 : (r[11:0] & 12'o7776));
            put(0, p + 12'o101, 12'o0001);
            put(0, p + 12'o102, 12'o0020);
            run_and_compare("isz", p);
            check_mem("isz word", 0, p + 12'o100);
        end

        // indirect through an auto-index location and a plain pointer
        p = pick_origin();
        r = next_random();
        a = 12'o0010 + r[2:0];
        b = 12'o3000 + r[23:16];
        put(0, a, b - 12'd1);
        put(0, 12'o0070, b + 12'o0400);
        put(0, b, r[11:0]);
        put(0, b + 12'o0400, r[27:16]);
        put(0, p, 12'o7200);
        put(0, p + 1, 12'o1400 | a);
        put(0, p + 2, 12'o1470);
        put(0, p + 3, 12'o7402);
        run_and_compare("defer", p);
        check_mem("auto index pointer", 0, a);
        check_mem("plain pointer", 0, 12'o0070);

        // jms stores the return and comes back through jmp i
        p = pick_origin();
        r = next_random();
        put(0, p, 12'o7200);
        put(0, p + 1, 12'o4240);
        put(0, p + 2, 12'o7402);
        put(0, p + 12'o40, 12'o0000);
        put(0, p + 12'o41, 12'o1300);
        put(0, p + 12'o42, 12'o5640);
        put(0, p + 12'o100, r[11:0]);
        run_and_compare("jms", p);
        check_mem("jms return", 0, p + 12'o40);

        // interrupt turns the execute cycle into jms 0
        p = pick_origin();
        put(0, 12'o0000, 12'o0000);
        put(0, 12'o0001, 12'o7402);
        put(0, p, 12'o1300);
        put(0, p + 12'o100, 12'o0123);
        int_in_prog = 1'b1;
        run_and_compare("interrupt", p);
        int_in_prog = 1'b0;
        check_mem("interrupt return", 0, 12'o0000);

        // indirect data references land in the data field
        p = pick_origin();
        r = next_random();
        a = 12'o2000 + r[7:0];
        b = a + 12'o0400;
        df_field = 3'd2;
        put(0, 12'o0050, a);
        put(0, 12'o0051, b);
        put(2, a, r[27:16]);
        put(2, b, 12'o0000);
        put(0, b, 12'o5555);
        put(0, p, 12'o7200);
        put(0, p + 1, 12'o1450);
        put(0, p + 2, 12'o3451);
        put(0, p + 3, 12'o1450);
        put(0, p + 4, 12'o7402);
        run_and_compare("data field", p);
        check_mem("data field store", 2, b);
        check_mem("instruction field untouched", 0, b);

        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule
